// File: issue_pkg.sv
/*
 * Shared widths, operation codes and unit-type masks for the issue stage.
 * Modules import this package inside their body and use scoped names in headers.
 */

package issue_pkg;

    localparam int DATA_WIDTH    = 32;
    localparam int ROB_IDX_WIDTH = 5;
    localparam int OP_WIDTH      = 4;

    // One bit per functional unit type, integer first and load/store second
    localparam int FU_TYPE_WIDTH = 2;

    typedef logic [DATA_WIDTH-1:0]    data_t;
    typedef logic [ROB_IDX_WIDTH-1:0] rob_tag_t;
    typedef logic [OP_WIDTH-1:0]      op_t;
    typedef logic [FU_TYPE_WIDTH-1:0] fu_type_t;

    // Integer operations
    localparam op_t OP_ADD = 4'h0;
    localparam op_t OP_SUB = 4'h1;
    localparam op_t OP_AND = 4'h2;
    localparam op_t OP_OR  = 4'h3;
    localparam op_t OP_XOR = 4'h4;
    localparam op_t OP_SLL = 4'h5;

    // Memory operations, handled only by the load/store unit
    localparam op_t OP_LD  = 4'h8;
    localparam op_t OP_ST  = 4'h9;

    // A station may support more than one type by setting several bits
    localparam fu_type_t FU_IEU = 2'b01;
    localparam fu_type_t FU_LSU = 2'b10;

endpackage

// File: rs_enq_if.sv
/*
 * Enqueue request from the switch into one reservation station.
 * The station answers with full, which the switch turns into a dispatch stall.
 */

`timescale 1ns/1ps

interface rs_enq_if;
    import issue_pkg::*;

    logic     en;
    op_t      op;
    logic     src_rdy  [0:1];
    data_t    src_data [0:1];
    rob_tag_t src_tag  [0:1];
    rob_tag_t dst_tag;
    logic     full;

    modport source (
        output en, op, src_rdy, src_data, src_tag, dst_tag,
        input  full
    );

    modport sink (
        input  en, op, src_rdy, src_data, src_tag, dst_tag,
        output full
    );

endinterface

// File: fu_issue_if.sv
/*
 * One issued instruction from a reservation station to its functional unit.
 * The unit always accepts, so there is no ready signal on this path.
 */

`timescale 1ns/1ps

interface fu_issue_if;
    import issue_pkg::*;

    logic     valid;
    op_t      op;
    data_t    src0;
    data_t    src1;
    rob_tag_t tag;

    modport source (output valid, op, src0, src1, tag);
    modport sink   (input  valid, op, src0, src1, tag);

endinterface

// File: rr_picker.sv
/*
 * Round-robin arbiter over a request vector.
 * The pointer moves past the grant only when the caller reports it was used.
 */

`timescale 1ns/1ps

module rr_picker #(
    parameter int OPTN_WIDTH = 3
)(
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic [OPTN_WIDTH-1:0] i_requests,
    input  logic                  i_advance,
    output logic [OPTN_WIDTH-1:0] o_grant
);

    // One-hot position where the search for the next grant starts
    logic [OPTN_WIDTH-1:0] ptr;
    logic [OPTN_WIDTH-1:0] req_hi;

    // Requests at or above the pointer win, otherwise wrap around to the lowest
    assign req_hi = i_requests & ~(ptr - 1'b1);

    always_comb begin
        if (|req_hi) begin
            o_grant = req_hi & (~req_hi + 1'b1);
        end else begin
            o_grant = i_requests & (~i_requests + 1'b1);
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            ptr <= OPTN_WIDTH'(1);
        end else if (i_advance && |o_grant) begin
            ptr <= (o_grant << 1) | (o_grant >> (OPTN_WIDTH - 1));
        end
    end

endmodule

// File: rs_switch.sv
/*
 * Steers each dispatched instruction to a station of the matching unit type.
 * Sources that appear on the result bus in the enqueue cycle are bypassed here.
 */

`timescale 1ns/1ps

module rs_switch #(
    parameter int                 OPTN_CDB_DEPTH = 3,
    parameter issue_pkg::fu_type_t OPTN_RS_FU_TYPES [0:OPTN_CDB_DEPTH-1] =
        '{issue_pkg::FU_IEU, issue_pkg::FU_IEU, issue_pkg::FU_LSU}
)(
    input  logic               clk,
    input  logic               i_reset,

    input  logic               i_dispatch_en,
    input  issue_pkg::op_t     i_dispatch_op,
    input  logic               i_dispatch_src_rdy  [0:1],
    input  issue_pkg::data_t   i_dispatch_src_data [0:1],
    input  issue_pkg::rob_tag_t i_dispatch_src_tag [0:1],
    input  issue_pkg::rob_tag_t i_dispatch_dst_tag,
    output logic               o_dispatch_stall,

    input  logic               i_cdb_en   [0:OPTN_CDB_DEPTH-1],
    input  issue_pkg::data_t   i_cdb_data [0:OPTN_CDB_DEPTH-1],
    input  issue_pkg::rob_tag_t i_cdb_tag [0:OPTN_CDB_DEPTH-1],

    rs_enq_if.source           o_rs_enq [0:OPTN_CDB_DEPTH-1]
);

    import issue_pkg::*;

    logic                      is_mem;
    fu_type_t                  fu_need;
    logic [OPTN_CDB_DEPTH-1:0] rs_supported;
    logic [OPTN_CDB_DEPTH-1:0] rs_granted;
    logic [OPTN_CDB_DEPTH-1:0] rs_full;
    logic                      dispatch_accept;

    logic     src_rdy  [0:1];
    data_t    src_data [0:1];
    rob_tag_t src_tag  [0:1];

    // Loads and stores need the load/store unit, everything else goes to integer
    assign is_mem  = (i_dispatch_op == OP_LD) || (i_dispatch_op == OP_ST);
    assign fu_need = is_mem ? FU_LSU : FU_IEU;

    always_comb begin
        for (int rs = 0; rs < OPTN_CDB_DEPTH; rs++) begin
            rs_supported[rs] = |(OPTN_RS_FU_TYPES[rs] & fu_need);
        end
    end

    rr_picker #(
        .OPTN_WIDTH (OPTN_CDB_DEPTH)
    ) rs_picker (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_requests (rs_supported),
        .i_advance  (dispatch_accept),
        .o_grant    (rs_granted)
    );

    // Back-pressure comes straight from the granted station
    assign o_dispatch_stall = i_dispatch_en & |(rs_granted & rs_full);
    assign dispatch_accept  = i_dispatch_en & ~o_dispatch_stall;

    // A waiting source takes the value of any lane that broadcasts its tag now
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src_rdy[s]  = i_dispatch_src_rdy[s];
            src_data[s] = i_dispatch_src_data[s];
            src_tag[s]  = i_dispatch_src_tag[s];
            if (!i_dispatch_src_rdy[s]) begin
                for (int c = 0; c < OPTN_CDB_DEPTH; c++) begin
                    if (i_cdb_en[c] && (i_cdb_tag[c] == i_dispatch_src_tag[s])) begin
                        src_rdy[s]  = 1'b1;
                        src_data[s] = i_cdb_data[c];
                    end
                end
            end
        end
    end

    for (genvar g = 0; g < OPTN_CDB_DEPTH; g++) begin : g_rs_enq
        assign o_rs_enq[g].en       = dispatch_accept & rs_granted[g];
        assign o_rs_enq[g].op       = i_dispatch_op;
        assign o_rs_enq[g].src_rdy  = src_rdy;
        assign o_rs_enq[g].src_data = src_data;
        assign o_rs_enq[g].src_tag  = src_tag;
        assign o_rs_enq[g].dst_tag  = i_dispatch_dst_tag;
        assign rs_full[g]           = o_rs_enq[g].full;
    end

endmodule

// File: reservation_station.sv
/*
 * Holds waiting instructions until both sources are ready, snooping every bus lane.
 * Issues the lowest ready entry each cycle through a registered output.
 */

`timescale 1ns/1ps

module reservation_station #(
    parameter int OPTN_RS_DEPTH  = 4,
    parameter int OPTN_CDB_DEPTH = 3
)(
    input  logic                clk,
    input  logic                i_reset,

    rs_enq_if.sink              i_enq,

    input  logic                i_cdb_en   [0:OPTN_CDB_DEPTH-1],
    input  issue_pkg::data_t    i_cdb_data [0:OPTN_CDB_DEPTH-1],
    input  issue_pkg::rob_tag_t i_cdb_tag  [0:OPTN_CDB_DEPTH-1],

    fu_issue_if.source          o_issue
);

    import issue_pkg::*;

    logic [OPTN_RS_DEPTH-1:0] entry_valid;
    op_t                      entry_op   [0:OPTN_RS_DEPTH-1];
    rob_tag_t                 entry_dst  [0:OPTN_RS_DEPTH-1];
    logic                     entry_rdy  [0:OPTN_RS_DEPTH-1][0:1];
    data_t                    entry_data [0:OPTN_RS_DEPTH-1][0:1];
    rob_tag_t                 entry_tag  [0:OPTN_RS_DEPTH-1][0:1];

    logic [OPTN_RS_DEPTH-1:0] enq_sel;
    logic [OPTN_RS_DEPTH-1:0] issue_ready;
    logic [OPTN_RS_DEPTH-1:0] issue_sel;

    op_t      sel_op;
    data_t    sel_src0;
    data_t    sel_src1;
    rob_tag_t sel_dst;

    // Lowest free slot takes the next enqueue
    assign enq_sel    = ~entry_valid & (entry_valid + 1'b1);
    assign i_enq.full = &entry_valid;

    always_comb begin
        for (int i = 0; i < OPTN_RS_DEPTH; i++) begin
            issue_ready[i] = entry_valid[i] & entry_rdy[i][0] & entry_rdy[i][1];
        end
    end

    assign issue_sel = issue_ready & (~issue_ready + 1'b1);

    always_comb begin
        sel_op   = '0;
        sel_src0 = '0;
        sel_src1 = '0;
        sel_dst  = '0;
        for (int i = 0; i < OPTN_RS_DEPTH; i++) begin
            if (issue_sel[i]) begin
                sel_op   = entry_op[i];
                sel_src0 = entry_data[i][0];
                sel_src1 = entry_data[i][1];
                sel_dst  = entry_dst[i];
            end
        end
    end

    // An issued entry is freed at the same edge the issue register loads
    always_ff @(posedge clk) begin
        if (i_reset) begin
            entry_valid   <= '0;
            o_issue.valid <= 1'b0;
        end else begin
            entry_valid   <= (entry_valid & ~issue_sel) | (i_enq.en ? enq_sel : '0);
            o_issue.valid <= |issue_sel;
        end
    end

    always_ff @(posedge clk) begin
        o_issue.op   <= sel_op;
        o_issue.src0 <= sel_src0;
        o_issue.src1 <= sel_src1;
        o_issue.tag  <= sel_dst;
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < OPTN_RS_DEPTH; i++) begin
            if (i_enq.en && enq_sel[i]) begin
                entry_op[i]  <= i_enq.op;
                entry_dst[i] <= i_enq.dst_tag;
                entry_rdy[i] <= i_enq.src_rdy;
                entry_data[i] <= i_enq.src_data;
                entry_tag[i] <= i_enq.src_tag;
            end else begin
                // Wakeup of sources still waiting on a producer
                for (int s = 0; s < 2; s++) begin
                    for (int c = 0; c < OPTN_CDB_DEPTH; c++) begin
                        if (entry_valid[i] && !entry_rdy[i][s] && i_cdb_en[c] &&
                            (i_cdb_tag[c] == entry_tag[i][s])) begin
                            entry_rdy[i][s]  <= 1'b1;
                            entry_data[i][s] <= i_cdb_data[c];
                        end
                    end
                end
            end
        end
    end

endmodule

// File: int_exec_unit.sv
/*
 * Integer unit that computes one result per issue and drives its own bus lane.
 */

`timescale 1ns/1ps

module int_exec_unit (
    input  logic                clk,
    input  logic                i_reset,
    fu_issue_if.sink            i_issue,
    output logic                o_cdb_en,
    output issue_pkg::data_t    o_cdb_data,
    output issue_pkg::rob_tag_t o_cdb_tag
);

    import issue_pkg::*;

    data_t result;

    always_comb begin
        case (i_issue.op)
            OP_ADD:  result = i_issue.src0 + i_issue.src1;
            OP_SUB:  result = i_issue.src0 - i_issue.src1;
            OP_AND:  result = i_issue.src0 & i_issue.src1;
            OP_OR:   result = i_issue.src0 | i_issue.src1;
            OP_XOR:  result = i_issue.src0 ^ i_issue.src1;
            // Shift amount comes from src0, only its low five bits count
            OP_SLL:  result = i_issue.src1 << i_issue.src0[4:0];
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_cdb_en <= 1'b0;
        end else begin
            o_cdb_en <= i_issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        o_cdb_data <= result;
        o_cdb_tag  <= i_issue.tag;
    end

endmodule

// File: lsu_exec_unit.sv
/*
 * Load/store unit backed by a small word-addressed scratch memory.
 * Stores broadcast the stored value, loads broadcast the word they read.
 */

`timescale 1ns/1ps

module lsu_exec_unit #(
    parameter int OPTN_LSU_MEM_WORDS = 16
)(
    input  logic                clk,
    input  logic                i_reset,
    fu_issue_if.sink            i_issue,
    output logic                o_cdb_en,
    output issue_pkg::data_t    o_cdb_data,
    output issue_pkg::rob_tag_t o_cdb_tag
);

    import issue_pkg::*;

    localparam int ADDR_WIDTH = $clog2(OPTN_LSU_MEM_WORDS);

    data_t                 mem [0:OPTN_LSU_MEM_WORDS-1];
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic                  is_store;

    assign mem_addr = ADDR_WIDTH'(i_issue.src0 % OPTN_LSU_MEM_WORDS);
    assign is_store = i_issue.op == OP_ST;

    // The whole scratch array starts out as zero after reset
    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int w = 0; w < OPTN_LSU_MEM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (i_issue.valid && is_store) begin
            mem[mem_addr] <= i_issue.src1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_cdb_en <= 1'b0;
        end else begin
            o_cdb_en <= i_issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        o_cdb_data <= is_store ? i_issue.src1 : mem[mem_addr];
        o_cdb_tag  <= i_issue.tag;
    end

endmodule

// File: issue_cluster.sv
/*
 * Top level of the issue stage: switch, reservation stations and functional units.
 * Each station and unit pair owns one lane of the result bus.
 */

`timescale 1ns/1ps

module issue_cluster #(
    parameter int                  OPTN_CDB_DEPTH     = 3,
    parameter int                  OPTN_RS_DEPTH      = 4,
    parameter int                  OPTN_LSU_MEM_WORDS = 16,
    parameter issue_pkg::fu_type_t OPTN_RS_FU_TYPES [0:OPTN_CDB_DEPTH-1] =
        '{issue_pkg::FU_IEU, issue_pkg::FU_IEU, issue_pkg::FU_LSU}
)(
    input  logic                clk,
    input  logic                i_reset,

    input  logic                i_dispatch_en,
    input  issue_pkg::op_t      i_dispatch_op,
    input  logic                i_dispatch_src_rdy  [0:1],
    input  issue_pkg::data_t    i_dispatch_src_data [0:1],
    input  issue_pkg::rob_tag_t i_dispatch_src_tag  [0:1],
    input  issue_pkg::rob_tag_t i_dispatch_dst_tag,
    output logic                o_dispatch_stall,

    output logic                o_cdb_en   [0:OPTN_CDB_DEPTH-1],
    output issue_pkg::data_t    o_cdb_data [0:OPTN_CDB_DEPTH-1],
    output issue_pkg::rob_tag_t o_cdb_tag  [0:OPTN_CDB_DEPTH-1]
);

    import issue_pkg::*;

    rs_enq_if   rs_enq   [0:OPTN_CDB_DEPTH-1] ();
    fu_issue_if fu_issue [0:OPTN_CDB_DEPTH-1] ();

    rs_switch #(
        .OPTN_CDB_DEPTH   (OPTN_CDB_DEPTH),
        .OPTN_RS_FU_TYPES (OPTN_RS_FU_TYPES)
    ) switch (
        .clk                 (clk),
        .i_reset             (i_reset),
        .i_dispatch_en       (i_dispatch_en),
        .i_dispatch_op       (i_dispatch_op),
        .i_dispatch_src_rdy  (i_dispatch_src_rdy),
        .i_dispatch_src_data (i_dispatch_src_data),
        .i_dispatch_src_tag  (i_dispatch_src_tag),
        .i_dispatch_dst_tag  (i_dispatch_dst_tag),
        .o_dispatch_stall    (o_dispatch_stall),
        .i_cdb_en            (o_cdb_en),
        .i_cdb_data          (o_cdb_data),
        .i_cdb_tag           (o_cdb_tag),
        .o_rs_enq            (rs_enq)
    );

    for (genvar g = 0; g < OPTN_CDB_DEPTH; g++) begin : g_lane
        reservation_station #(
            .OPTN_RS_DEPTH  (OPTN_RS_DEPTH),
            .OPTN_CDB_DEPTH (OPTN_CDB_DEPTH)
        ) rs (
            .clk        (clk),
            .i_reset    (i_reset),
            .i_enq      (rs_enq[g]),
            .i_cdb_en   (o_cdb_en),
            .i_cdb_data (o_cdb_data),
            .i_cdb_tag  (o_cdb_tag),
            .o_issue    (fu_issue[g])
        );

        // The unit behind each station follows the station's type mask
        if (OPTN_RS_FU_TYPES[g] == FU_LSU) begin : g_lsu
            lsu_exec_unit #(
                .OPTN_LSU_MEM_WORDS (OPTN_LSU_MEM_WORDS)
            ) lsu (
                .clk        (clk),
                .i_reset    (i_reset),
                .i_issue    (fu_issue[g]),
                .o_cdb_en   (o_cdb_en[g]),
                .o_cdb_data (o_cdb_data[g]),
                .o_cdb_tag  (o_cdb_tag[g])
            );
        end else begin : g_ieu
            int_exec_unit ieu (
                .clk        (clk),
                .i_reset    (i_reset),
                .i_issue    (fu_issue[g]),
                .o_cdb_en   (o_cdb_en[g]),
                .o_cdb_data (o_cdb_data[g]),
                .o_cdb_tag  (o_cdb_tag[g])
            );
        end
    end

endmodule

// File: tb_clock_gen.sv
/*
 * Testbench clock and synchronous reset source.
 * Reset is released on a rising edge after RESET_CYCLES cycles.
 */

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 5
)(
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_reset <= 1'b0;
    end

endmodule

// File: issue_cluster_tb.sv
/*
 * Testbench for the issue stage. Plays the dispatcher from dispatch_cases.txt,
 * scoreboards every result bus broadcast and checks lane steering and stalls.
 */

`timescale 1ns/1ps

module issue_cluster_tb;
    import issue_pkg::*;

    localparam int LANES      = 3;
    localparam int MAX_CASES  = 32;
    localparam int TAGS       = 1 << ROB_IDX_WIDTH;
    localparam int CASE_LIMIT = 200;

    logic     clk;
    logic     rst;
    logic     dispatch_en;
    op_t      dispatch_op;
    logic     src_rdy  [0:1];
    data_t    src_data [0:1];
    rob_tag_t src_tag  [0:1];
    rob_tag_t dst_tag;
    logic     dispatch_stall;
    logic     cdb_en   [0:LANES-1];
    data_t    cdb_data [0:LANES-1];
    rob_tag_t cdb_tag  [0:LANES-1];

    // Cases as read from the data file
    op_t      case_op  [0:MAX_CASES-1];
    logic     case_rdy [0:MAX_CASES-1][0:1];
    data_t    case_src [0:MAX_CASES-1][0:1];
    rob_tag_t case_dst [0:MAX_CASES-1];
    logic     case_bar [0:MAX_CASES-1];
    data_t    case_exp [0:MAX_CASES-1];
    int       num_cases;

    // Scoreboard indexed by destination tag
    logic     dispatched [0:TAGS-1];
    int       exp_lane   [0:TAGS-1];
    data_t    exp_data   [0:TAGS-1];
    int       seen       [0:TAGS-1];

    int error_count;
    int stall_cycles;
    int last_lane;

    tb_clock_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (5)
    ) clock_gen (
        .o_clk   (clk),
        .o_reset (rst)
    );

    issue_cluster i_dut (
        .clk                 (clk),
        .i_reset             (rst),
        .i_dispatch_en       (dispatch_en),
        .i_dispatch_op       (dispatch_op),
        .i_dispatch_src_rdy  (src_rdy),
        .i_dispatch_src_data (src_data),
        .i_dispatch_src_tag  (src_tag),
        .i_dispatch_dst_tag  (dst_tag),
        .o_dispatch_stall    (dispatch_stall),
        .o_cdb_en            (cdb_en),
        .o_cdb_data          (cdb_data),
        .o_cdb_tag           (cdb_tag)
    );

    // Memory ops own lane 2, integer ops take stations 0 and 1 in turn
    // starting just past the last accepted grant
    function automatic int pick_lane(input op_t op, input int prev_lane);
        if (op == OP_LD || op == OP_ST) begin
            return 2;
        end
        return (prev_lane == 0) ? 1 : 0;
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int t = 0; t < TAGS; t++) begin
            if (dispatched[t] && seen[t] == 0) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op, f_r0, f_v0, f_r1, f_v1, f_dst, f_bar, f_exp;
        num_cases = 0;
        fd = $fopen("dispatch_cases.txt", "r");
        assert (fd != 0) else begin
            $display("Could not open dispatch_cases.txt for reading");
            error_count++;
        end
        if (fd != 0) begin
            while (!$feof(fd) && num_cases < MAX_CASES) begin
                line = "";
                n = $fgets(line, fd);
                // Comment and blank lines do not yield all eight fields
                n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                            f_op, f_r0, f_v0, f_r1, f_v1, f_dst, f_bar, f_exp);
                if (n == 8) begin
                    case_op[num_cases]     = op_t'(f_op);
                    case_rdy[num_cases][0] = f_r0[0];
                    case_src[num_cases][0] = f_v0;
                    case_rdy[num_cases][1] = f_r1[0];
                    case_src[num_cases][1] = f_v1;
                    case_dst[num_cases]    = rob_tag_t'(f_dst);
                    case_bar[num_cases]    = f_bar[0];
                    case_exp[num_cases]    = f_exp;
                    num_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_quiet_outputs();
        for (int c = 0; c < LANES; c++) begin
            assert (cdb_en[c] === 1'b0) else begin
                $display("Fail %0t ns: o_cdb_en[%0d] expected 0, actual %b", $time, c, cdb_en[c]);
                error_count++;
            end
        end
        assert (dispatch_stall === 1'b0) else begin
            $display("Fail %0t ns: o_dispatch_stall expected 0, actual %b", $time, dispatch_stall);
            error_count++;
        end
    endtask

    task automatic check_broadcast(input int lane, input rob_tag_t tag, input data_t data);
        assert (dispatched[tag]) else begin
            $display("Lane %0d broadcast tag %0d at %0t ns, which was never dispatched",
                     lane, tag, $time);
            error_count++;
        end
        assert (seen[tag] == 0) else begin
            $display("Tag %0d was broadcast again at %0t ns on lane %0d", tag, $time, lane);
            error_count++;
        end
        if (dispatched[tag]) begin
            assert (lane == exp_lane[tag]) else begin
                $display("Fail %0t ns: o_cdb_en lane for tag %0d expected %0d, actual %0d",
                         $time, tag, exp_lane[tag], lane);
                error_count++;
            end
            assert (data == exp_data[tag]) else begin
                $display("Fail %0t ns: o_cdb_data[%0d] for tag %0d expected %h, actual %h",
                         $time, lane, tag, exp_data[tag], data);
                error_count++;
            end
        end
        seen[tag]++;
    endtask

    // Presents one case and returns on the falling edge before it is accepted
    task automatic send_case(input int k);
        int lane;
        @(posedge clk);
        dispatch_en <= 1'b1;
        dispatch_op <= case_op[k];
        for (int s = 0; s < 2; s++) begin
            src_rdy[s]  <= case_rdy[k][s];
            src_data[s] <= case_rdy[k][s] ? case_src[k][s] : '0;
            src_tag[s]  <= case_src[k][s][ROB_IDX_WIDTH-1:0];
        end
        dst_tag <= case_dst[k];
        @(negedge clk);
        while (dispatch_stall) begin
            stall_cycles++;
            @(negedge clk);
        end
        lane = pick_lane(case_op[k], last_lane);
        last_lane = lane;
        exp_lane[case_dst[k]]   = lane;
        exp_data[case_dst[k]]   = case_exp[k];
        dispatched[case_dst[k]] = 1'b1;
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            for (int c = 0; c < LANES; c++) begin
                if (cdb_en[c]) begin
                    check_broadcast(c, cdb_tag[c], cdb_data[c]);
                end
            end
        end
    end

    initial begin : main
        int   gap;
        logic gap_next;
        $timeformat(-9, 0, "", 0);
        void'($urandom(32'h949d));
        dispatch_en = 1'b0;
        dispatch_op = OP_ADD;
        for (int s = 0; s < 2; s++) begin
            src_rdy[s]  = 1'b0;
            src_data[s] = '0;
            src_tag[s]  = '0;
        end
        dst_tag = '0;
        error_count  = 0;
        stall_cycles = 0;
        last_lane    = LANES - 1;
        for (int t = 0; t < TAGS; t++) begin
            dispatched[t] = 1'b0;
            seen[t]       = 0;
            exp_lane[t]   = -1;
            exp_data[t]   = '0;
        end
        load_cases();
        assert (num_cases > 0) else begin
            $display("No dispatch cases were read from the data file");
            error_count++;
        end

        // Outputs stay quiet through reset and on the first cycle after it
        do begin
            @(negedge clk);
            check_quiet_outputs();
        end while (rst);
        @(negedge clk);
        check_quiet_outputs();

        gap_next = 1'b0;
        for (int k = 0; k < num_cases; k++) begin
            if (gap_next) begin
                gap = $urandom_range(3, 0);
                repeat (gap) @(posedge clk);
            end
            send_case(k);
            gap_next = 1'b0;
            if (case_bar[k]) begin
                @(posedge clk);
                dispatch_en <= 1'b0;
                while (seen[case_dst[k]] == 0) @(posedge clk);
                gap_next = 1'b1;
            end
        end
        @(posedge clk);
        dispatch_en <= 1'b0;
        while (outstanding() != 0) @(posedge clk);
        // A few more cycles catch late duplicate broadcasts
        repeat (10) @(posedge clk);

        for (int k = 0; k < num_cases; k++) begin
            assert (seen[case_dst[k]] == 1) else begin
                $display("Tag %0d was broadcast %0d times instead of once",
                         case_dst[k], seen[case_dst[k]]);
                error_count++;
            end
        end
        assert (stall_cycles > 0) else begin
            $display("Dispatch stall never went high while the integer stations were full");
            error_count++;
        end

        $display("Closing: %0d errors, %0d cases, %0d stall cycles",
                 error_count, num_cases, stall_cycles);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (num_cases > 0);
        repeat (num_cases * CASE_LIMIT) @(posedge clk);
        $display("Run timed out after %0d cycles with %0d results still outstanding",
                 num_cases * CASE_LIMIT, outstanding());
        $display("Closing: %0d errors, %0d cases, %0d stall cycles",
                 error_count + 1, num_cases, stall_cycles);
        $display("Verification failed");
        $finish;
    end

endmodule

// File: issue_cluster.f
issue_pkg.sv
rs_enq_if.sv
fu_issue_if.sv
rr_picker.sv
rs_switch.sv
reservation_station.sv
int_exec_unit.sv
lsu_exec_unit.sv
issue_cluster.sv
tb_clock_gen.sv
issue_cluster_tb.sv

// File: Makefile
# Verilator build for the issue stage testbench
# Pass or fail is decided by searching the simulator output for the pass message

VERILATOR ?= verilator
TOP       ?= issue_cluster_tb
RTL_TOP   ?= issue_cluster
FILELIST  ?= issue_cluster.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall
PASS_MSG  ?= Verification passed

RTL_SRCS ?= issue_pkg.sv rs_enq_if.sv fu_issue_if.sv rr_picker.sv rs_switch.sv \
            reservation_station.sv int_exec_unit.sv lsu_exec_unit.sv issue_cluster.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)

// File: dispatch_cases.txt
# op r0 src0     r1 src1     dst bar expected
# All hex. With r set to 0 the source field holds the producer's tag instead of a value
# Integer results with ready sources
0 1 00000005 1 00000003 01 0 00000008
1 1 00000010 1 00000003 02 0 0000000d
2 1 0000ff0f 1 000f0ff0 03 0 00000f00
3 1 a0000000 1 0000000a 04 0 a000000a
4 1 ffff0000 1 0f0f0f0f 05 0 f0f00f0f
5 1 00000004 1 00000003 06 0 00000030
5 1 00000024 1 00000001 07 0 00000010
1 1 00000000 1 00000001 08 1 ffffffff
# Wakeup by snooping, bypass on the enqueue cycle and a dependency chain
0 1 00000100 1 00000023 09 0 00000123
1 0 00000009 1 00000003 0a 0 00000120
4 1 0000ffff 0 00000009 0b 0 0000fedc
0 0 00000009 0 0000000a 0c 0 00000243
5 1 00000008 0 0000000c 0d 1 00024300
# Memory round trip, address 0x13 wraps to word 3
9 1 00000003 1 cafef00d 0e 1 cafef00d
8 1 00000013 1 00000000 0f 0 cafef00d
8 1 00000007 1 00000000 10 0 00000000
9 1 00000005 0 0000000f 11 1 cafef00d
8 1 00000005 1 00000000 12 1 cafef00d
# Slow load chain on an unwritten word, then enough dependents to fill stations 0 and 1
8 1 00000000 1 00000000 13 0 00000000
8 0 00000013 1 00000000 14 0 00000000
8 0 00000014 1 00000000 15 0 00000000
8 0 00000015 1 00000000 16 0 00000000
0 0 00000016 1 00000011 17 0 00000011
3 0 00000016 1 00000022 18 0 00000022
4 0 00000016 1 00000033 19 0 00000033
1 0 00000016 1 00000044 1a 0 ffffffbc
2 0 00000016 1 ffffffff 1b 0 00000000
5 0 00000016 1 00000055 1c 0 00000055
0 1 00000100 0 00000016 1d 0 00000100
1 0 00000016 0 00000016 1e 0 00000000
0 1 00000040 1 00000002 1f 0 00000042
